// File: mem_defines.svh
/*
 * parameters of the memory subsystem
 * RAM depth, base address, data and instruction widths
 */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// word-index width of the RAM
`define MEM_ADDR_BITS 8
`define MEM_WORDS (1 << `MEM_ADDR_BITS)

// byte address of the first RAM word
`define MEM_BASE 64'h0000_0000_8000_0000

// data path
`define XLEN 64
`define XLEN_BYTES (`XLEN / 8)
`define OFF_BITS 3

// instruction width
`define INST_W 32

`endif

// File: mem_pkg.sv
/*
 * shared types of the memory subsystem
 * address, data, mask and index vectors, access size and arbiter enums,
 * port request and response structs
 */
`include "mem_defines.svh"

package mem_pkg;

    typedef logic [`XLEN-1:0]          addr_t;
    typedef logic [`XLEN-1:0]          word_t;
    typedef logic [`INST_W-1:0]        inst_t;
    typedef logic [`XLEN_BYTES-1:0]    bmask_t;
    typedef logic [`MEM_ADDR_BITS-1:0] ram_idx_t;

    typedef enum logic [1:0] {
        SZ_B,
        SZ_H,
        SZ_W,
        SZ_D
    } acc_size_e;

    // round-robin owner of the last grant
    typedef enum logic {
        PORT_FETCH,
        PORT_LSU
    } port_sel_e;

    typedef struct packed {
        logic      wr;
        acc_size_e size;
        logic      uns;
        addr_t     addr;
        word_t     wdata;
    } lsu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  err;
    } lsu_rsp_t;

    typedef struct packed {
        inst_t inst;
        logic  err;
    } fetch_rsp_t;

    typedef struct packed {
        ram_idx_t idx;
        logic     we;
        bmask_t   mask;
        word_t    wdata;
    } ram_req_t;

endpackage

// File: data_ram.sv
/*
 * single-port data RAM
 * 64-bit words, per-byte write enables, registered read port
 */
`include "mem_defines.svh"

module data_ram (
    input  logic              clk,
    input  mem_pkg::ram_req_t ram_req,
    input  logic              ram_en,
    output mem_pkg::word_t    rdata
);
    import mem_pkg::*;

    word_t mem [`MEM_WORDS];

    // whole array comes up cleared
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte-masked write at the grant edge
    always @(posedge clk) begin
        if (ram_en && ram_req.we) begin
            for (int b = 0; b < `XLEN_BYTES; b++) begin
                if (ram_req.mask[b]) begin
                    mem[ram_req.idx][8*b +: 8] <= ram_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data valid the cycle after ram_en
    // the old word read on a write goes unused
    always_ff @(posedge clk) begin
        if (ram_en) begin
            rdata <= mem[ram_req.idx];
        end
    end

endmodule

// File: mem_arbiter.sv
/*
 * round-robin arbiter between fetch and load/store ports
 * owns the data RAM and tags each returning word with its port
 */
module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_pend,
    input  mem_pkg::ram_req_t fetch_ram_req,
    input  logic              lsu_pend,
    input  mem_pkg::ram_req_t lsu_ram_req,
    output logic              fetch_gnt,
    output logic              lsu_gnt,
    output logic              fetch_ret,
    output logic              lsu_ret,
    output mem_pkg::word_t    ram_rdata
);
    import mem_pkg::*;

    port_sel_e last_q;
    ram_req_t  ram_req;
    logic      ram_en;

    // on a tie the port that lost last time wins
    assign fetch_gnt = fetch_pend && (!lsu_pend || last_q == PORT_LSU);
    assign lsu_gnt   = lsu_pend && (!fetch_pend || last_q == PORT_FETCH);

    assign ram_en  = fetch_gnt || lsu_gnt;
    assign ram_req = lsu_gnt ? lsu_ram_req : fetch_ram_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= PORT_LSU;
        end else if (fetch_gnt) begin
            last_q <= PORT_FETCH;
        end else if (lsu_gnt) begin
            last_q <= PORT_LSU;
        end
    end

    // grant delayed by one cycle marks the data return
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ret <= 1'b0;
            lsu_ret   <= 1'b0;
        end else begin
            fetch_ret <= fetch_gnt;
            lsu_ret   <= lsu_gnt;
        end
    end

    data_ram u_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .ram_en  (ram_en),
        .rdata   (ram_rdata)
    );

endmodule

// File: lsu_port.sv
/*
 * load/store port
 * alignment check, store byte mask and lane shift,
 * load lane select with zero or sign extension
 */
`include "mem_defines.svh"

module lsu_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  mem_pkg::lsu_req_t req,
    output logic              rsp_valid,
    output mem_pkg::lsu_rsp_t rsp,
    output logic              pend,
    output mem_pkg::ram_req_t ram_req,
    input  logic              gnt,
    input  logic              ret,
    input  mem_pkg::word_t    ram_rdata
);
    import mem_pkg::*;

    logic                 busy;
    logic                 accept;
    logic                 misaligned;
    bmask_t               mask_base;
    addr_t                off_addr;
    ram_req_t             ram_req_d;
    acc_size_e            size_q;
    logic                 uns_q;
    logic [`OFF_BITS-1:0] off_q;
    word_t                lane;
    word_t                load_data;

    // strobes while busy are dropped
    assign accept = req_valid && !busy;

    always_comb begin
        misaligned = 1'b0;
        mask_base  = '1;
        case (req.size)
            SZ_B: mask_base = 8'h01;
            SZ_H: begin
                misaligned = req.addr[0];
                mask_base  = 8'h03;
            end
            SZ_W: begin
                misaligned = |req.addr[1:0];
                mask_base  = 8'h0f;
            end
            default: misaligned = |req.addr[`OFF_BITS-1:0];
        endcase
    end

    assign off_addr        = req.addr - `MEM_BASE;
    assign ram_req_d.idx   = off_addr[`MEM_ADDR_BITS+`OFF_BITS-1:`OFF_BITS];
    assign ram_req_d.we    = req.wr;
    assign ram_req_d.mask  = mask_base << req.addr[`OFF_BITS-1:0];
    assign ram_req_d.wdata = req.wdata << {req.addr[`OFF_BITS-1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            pend <= 1'b0;
        end else if (accept && !misaligned) begin
            busy <= 1'b1;
            pend <= 1'b1;
        end else begin
            if (gnt) pend <= 1'b0;
            if (ret) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !misaligned) begin
            ram_req <= ram_req_d;
            size_q  <= req.size;
            uns_q   <= req.uns;
            off_q   <= req.addr[`OFF_BITS-1:0];
        end
    end

    // move the addressed lane down to bit 0
    assign lane = ram_rdata >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            SZ_B: load_data = uns_q ? {{(`XLEN-8){1'b0}}, lane[7:0]}
                                    : {{(`XLEN-8){lane[7]}}, lane[7:0]};
            SZ_H: load_data = uns_q ? {{(`XLEN-16){1'b0}}, lane[15:0]}
                                    : {{(`XLEN-16){lane[15]}}, lane[15:0]};
            SZ_W: load_data = uns_q ? {{(`XLEN-32){1'b0}}, lane[31:0]}
                                    : {{(`XLEN-32){lane[31]}}, lane[31:0]};
            default: load_data = lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) rsp_valid <= 1'b0;
        else     rsp_valid <= ret || (accept && misaligned);
    end

    // zero data for stores and for misaligned access
    always_ff @(posedge clk) begin
        if (ret) begin
            rsp.rdata <= ram_req.we ? '0 : load_data;
            rsp.err   <= 1'b0;
        end else if (accept && misaligned) begin
            rsp.rdata <= '0;
            rsp.err   <= 1'b1;
        end
    end

endmodule

// File: fetch_port.sv
/*
 * instruction fetch port
 * 4-byte alignment check, read-only RAM requests, half-word select
 */
`include "mem_defines.svh"

module fetch_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  mem_pkg::addr_t      req_addr,
    output logic                rsp_valid,
    output mem_pkg::fetch_rsp_t rsp,
    output logic                pend,
    output mem_pkg::ram_req_t   ram_req,
    input  logic                gnt,
    input  logic                ret,
    input  mem_pkg::word_t      ram_rdata
);
    import mem_pkg::*;

    logic     busy;
    logic     accept;
    logic     misaligned;
    addr_t    off_addr;
    ram_idx_t idx_q;
    logic     hi_q;

    assign accept     = req_valid && !busy;
    assign misaligned = |req_addr[1:0];
    assign off_addr   = req_addr - `MEM_BASE;

    // never writes
    assign ram_req.idx   = idx_q;
    assign ram_req.we    = 1'b0;
    assign ram_req.mask  = '0;
    assign ram_req.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            pend <= 1'b0;
        end else if (accept && !misaligned) begin
            busy <= 1'b1;
            pend <= 1'b1;
        end else begin
            if (gnt) pend <= 1'b0;
            if (ret) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !misaligned) begin
            idx_q <= off_addr[`MEM_ADDR_BITS+`OFF_BITS-1:`OFF_BITS];
            hi_q  <= req_addr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) rsp_valid <= 1'b0;
        else     rsp_valid <= ret || (accept && misaligned);
    end

    always_ff @(posedge clk) begin
        if (ret) begin
            rsp.inst <= hi_q ? ram_rdata[`XLEN-1 -: `INST_W] : ram_rdata[`INST_W-1:0];
            rsp.err  <= 1'b0;
        end else if (accept && misaligned) begin
            rsp.inst <= '0;
            rsp.err  <= 1'b1;
        end
    end

endmodule

// File: mem_subsys_top.sv
/*
 * memory subsystem top level
 * fetch port, load/store port, arbiter with data RAM
 */
module mem_subsys_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_req_valid,
    input  mem_pkg::addr_t      fetch_req_addr,
    output logic                fetch_rsp_valid,
    output mem_pkg::fetch_rsp_t fetch_rsp,
    input  logic                lsu_req_valid,
    input  mem_pkg::lsu_req_t   lsu_req,
    output logic                lsu_rsp_valid,
    output mem_pkg::lsu_rsp_t   lsu_rsp
);
    import mem_pkg::*;

    logic     fetch_pend;
    logic     lsu_pend;
    ram_req_t fetch_ram_req;
    ram_req_t lsu_ram_req;
    logic     fetch_gnt;
    logic     lsu_gnt;
    logic     fetch_ret;
    logic     lsu_ret;
    word_t    ram_rdata;

    fetch_port u_fetch (
        .clk       (clk),
        .rst       (rst),
        .req_valid (fetch_req_valid),
        .req_addr  (fetch_req_addr),
        .rsp_valid (fetch_rsp_valid),
        .rsp       (fetch_rsp),
        .pend      (fetch_pend),
        .ram_req   (fetch_ram_req),
        .gnt       (fetch_gnt),
        .ret       (fetch_ret),
        .ram_rdata (ram_rdata)
    );

    lsu_port u_lsu (
        .clk       (clk),
        .rst       (rst),
        .req_valid (lsu_req_valid),
        .req       (lsu_req),
        .rsp_valid (lsu_rsp_valid),
        .rsp       (lsu_rsp),
        .pend      (lsu_pend),
        .ram_req   (lsu_ram_req),
        .gnt       (lsu_gnt),
        .ret       (lsu_ret),
        .ram_rdata (ram_rdata)
    );

    mem_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .fetch_pend    (fetch_pend),
        .fetch_ram_req (fetch_ram_req),
        .lsu_pend      (lsu_pend),
        .lsu_ram_req   (lsu_ram_req),
        .fetch_gnt     (fetch_gnt),
        .lsu_gnt       (lsu_gnt),
        .fetch_ret     (fetch_ret),
        .lsu_ret       (lsu_ret),
        .ram_rdata     (ram_rdata)
    );

endmodule

// File: mem_assertions.sv
/*
 * concurrent checks bound into the arbiter and both ports
 * grant exclusivity, strobes only while idle, a return after every grant
 */
module mem_assertions (
    input logic clk,
    input logic rst,
    input logic gnt_a,
    input logic gnt_b,
    input logic ret_a,
    input logic ret_b,
    input logic strobe,
    input logic busy
);
    timeunit 1ns;
    timeprecision 100ps;

    grant_exclusive: assert property (@(posedge clk) disable iff (rst) !(gnt_a && gnt_b))
        else $error("both grants high in the same cycle");

    // busy covers pending and waiting for data
    strobe_when_idle: assert property (@(posedge clk) disable iff (rst) strobe |-> !busy)
        else $error("port strobed while a request is outstanding");

    return_after_gnt_a: assert property (@(posedge clk) disable iff (rst) gnt_a |=> ret_a)
        else $error("grant not followed by a return strobe");

    return_after_gnt_b: assert property (@(posedge clk) disable iff (rst) gnt_b |=> ret_b)
        else $error("grant not followed by a return strobe");

endmodule

// grants and returns in the arbiter and strobes in each port
bind mem_arbiter mem_assertions u_arb_chk (
    .clk(clk), .rst(rst), .gnt_a(fetch_gnt), .gnt_b(lsu_gnt),
    .ret_a(fetch_ret), .ret_b(lsu_ret), .strobe(1'b0), .busy(1'b0)
);

bind lsu_port mem_assertions u_lsu_chk (
    .clk(clk), .rst(rst), .gnt_a(gnt), .gnt_b(1'b0),
    .ret_a(ret), .ret_b(1'b0), .strobe(req_valid), .busy(busy)
);

bind fetch_port mem_assertions u_fetch_chk (
    .clk(clk), .rst(rst), .gnt_a(gnt), .gnt_b(1'b0),
    .ret_a(ret), .ret_b(1'b0), .strobe(req_valid), .busy(busy)
);

// File: tb_mem_subsys.sv
/*
 * testbench for the memory subsystem
 * byte-wide reference model, directed and random traffic on both ports,
 * in-order response checks and a watchdog
 */
`include "mem_defines.svh"

module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int N_RAND    = 150;
    // directed phases stay below 200 transactions
    localparam int N_TXN     = 200 + 2 * N_RAND;
    localparam int WORST_LAT = 10;
    localparam int RSP_LIMIT = 16;

    logic       clk = 1'b0;
    logic       rst;
    logic       fetch_req_valid;
    addr_t      fetch_req_addr;
    logic       fetch_rsp_valid;
    fetch_rsp_t fetch_rsp;
    logic       lsu_req_valid;
    lsu_req_t   lsu_req;
    logic       lsu_rsp_valid;
    lsu_rsp_t   lsu_rsp;

    logic [7:0] ref_mem [`MEM_WORDS * `XLEN_BYTES];
    lsu_rsp_t   lsu_exp[$];
    fetch_rsp_t fetch_exp[$];
    lsu_req_t   lsu_rand[$];
    addr_t      fetch_rand[$];
    int         lsu_sent = 0;
    int         lsu_done = 0;
    int         fetch_sent = 0;
    int         fetch_done = 0;
    int         seed = 37;

    always #2 clk = ~clk;

    mem_subsys_top u_dut (.*);

    function automatic addr_t word_addr(input int word, input int off);
        return `MEM_BASE + 64'(word * `XLEN_BYTES + off);
    endfunction

    function automatic word_t rand_word();
        word_t v;
        v[63:32] = $random(seed);
        v[31:0]  = $random(seed);
        return v;
    endfunction

    function automatic lsu_req_t build_req(input logic wr, input acc_size_e size,
                                           input logic uns, input addr_t addr,
                                           input word_t wdata);
        lsu_req_t r;
        r.wr    = wr;
        r.size  = size;
        r.uns   = uns;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // little-endian bytes extended from the top byte of the access
    function automatic lsu_rsp_t lsu_expected(input lsu_req_t r);
        lsu_rsp_t e;
        int       nb;
        int       base;
        e    = '0;
        nb   = 1 << int'(r.size);
        base = int'(r.addr - `MEM_BASE);
        if ((r.addr[2:0] & 3'(nb - 1)) != 3'b000) begin
            e.err = 1'b1;
        end else if (!r.wr) begin
            for (int i = 0; i < `XLEN_BYTES; i++) begin
                if (i < nb) e.rdata[8*i +: 8] = ref_mem[base + i];
                else e.rdata[8*i +: 8] = {8{!r.uns && ref_mem[base + nb - 1][7]}};
            end
        end
        return e;
    endfunction

    function automatic fetch_rsp_t fetch_expected(input addr_t a);
        fetch_rsp_t e;
        int         base;
        e    = '0;
        base = int'(a - `MEM_BASE);
        if (a[1:0] != 2'b00) begin
            e.err = 1'b1;
        end else begin
            for (int i = 0; i < `INST_W / 8; i++) begin
                e.inst[8*i +: 8] = ref_mem[base + i];
            end
        end
        return e;
    endfunction

    // misaligned stores leave the model untouched
    task automatic update_model(input lsu_req_t r);
        int nb;
        int base;
        nb   = 1 << int'(r.size);
        base = int'(r.addr - `MEM_BASE);
        if ((r.addr[2:0] & 3'(nb - 1)) == 3'b000) begin
            for (int i = 0; i < nb; i++) begin
                ref_mem[base + i] = r.wdata[8*i +: 8];
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_lsu_rsp(input lsu_rsp_t got, input lsu_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR lsu_rsp rdata=%h err=%h expected rdata=%h err=%h",
                                got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_fetch_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR fetch_rsp inst=%h err=%h expected inst=%h err=%h",
                                got.inst, got.err, exp.inst, exp.err));
        end
    endtask

    // one strobe and a wait for its checked response
    task automatic lsu_access(input lsu_req_t r);
        int waited;
        waited = 0;
        @(posedge clk);
        lsu_req_valid <= 1'b1;
        lsu_req       <= r;
        lsu_exp.push_back(lsu_expected(r));
        if (r.wr) update_model(r);
        lsu_sent++;
        @(posedge clk);
        lsu_req_valid <= 1'b0;
        while (lsu_done < lsu_sent) begin
            @(posedge clk);
            waited++;
            if (waited > RSP_LIMIT) abort_run("load/store port gave no response in time");
        end
    endtask

    task automatic fetch_access(input addr_t a);
        int waited;
        waited = 0;
        @(posedge clk);
        fetch_req_valid <= 1'b1;
        fetch_req_addr  <= a;
        fetch_exp.push_back(fetch_expected(a));
        fetch_sent++;
        @(posedge clk);
        fetch_req_valid <= 1'b0;
        while (fetch_done < fetch_sent) begin
            @(posedge clk);
            waited++;
            if (waited > RSP_LIMIT) abort_run("fetch port gave no response in time");
        end
    endtask

    // responses in order per port
    always @(posedge clk) begin
        if (!rst && lsu_rsp_valid) begin
            if (lsu_exp.size() == 0) begin
                abort_run("load/store port answered with no request outstanding");
            end else begin
                check_lsu_rsp(lsu_rsp, lsu_exp.pop_front());
                lsu_done <= lsu_done + 1;
            end
        end
        if (!rst && fetch_rsp_valid) begin
            if (fetch_exp.size() == 0) begin
                abort_run("fetch port answered with no request outstanding");
            end else begin
                check_fetch_rsp(fetch_rsp, fetch_exp.pop_front());
                fetch_done <= fetch_done + 1;
            end
        end
    end

    // reset plus every transaction at worst-case latency
    initial begin
        #((8 + N_TXN * WORST_LAT) * 4);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        int w;
        int nb;
        int off;
        int rv;
        rst             = 1'b1;
        fetch_req_valid = 1'b0;
        fetch_req_addr  = '0;
        lsu_req_valid   = 1'b0;
        lsu_req         = '0;
        for (int i = 0; i < `MEM_WORDS * `XLEN_BYTES; i++) begin
            ref_mem[i] = '0;
        end

        // random traffic keeps lsu in the upper half and fetch in the lower half
        for (int i = 0; i < N_RAND; i++) begin
            rv  = $random(seed);
            nb  = 1 << (rv & 3);
            off = (rv >> 2) & 7;
            if (((rv >> 5) & 7) != 0) off = off & ~(nb - 1);
            w   = `MEM_WORDS / 2 + ((rv >> 8) & (`MEM_WORDS / 2 - 1));
            lsu_rand.push_back(build_req(rv[24], acc_size_e'(rv[1:0]), rv[25],
                                         word_addr(w, off), rand_word()));
            rv  = $random(seed);
            off = ((rv & 15) == 0) ? ((rv >> 4) & 7) : ((rv >> 4) & 1) * 4;
            w   = (rv >> 8) & (`MEM_WORDS / 2 - 1);
            fetch_rand.push_back(word_addr(w, off));
        end

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // every store size and offset over a random background word
        w = 0;
        for (int s = 0; s < 4; s++) begin
            nb = 1 << s;
            for (int o = 0; o < `XLEN_BYTES; o += nb) begin
                lsu_access(build_req(1'b1, SZ_D, 1'b0, word_addr(w, 0), rand_word()));
                lsu_access(build_req(1'b1, acc_size_e'(s[1:0]), 1'b0, word_addr(w, o),
                                     rand_word()));
                lsu_access(build_req(1'b0, SZ_D, 1'b0, word_addr(w, 0), '0));
                w++;
            end
        end

        // lanes with both sign bit values
        lsu_access(build_req(1'b1, SZ_D, 1'b0, word_addr(20, 0), 64'hf1e2_83c4_7566_a708));
        for (int s = 0; s < 4; s++) begin
            nb = 1 << s;
            for (int o = 0; o < `XLEN_BYTES; o += nb) begin
                for (int u = 0; u < 2; u++) begin
                    lsu_access(build_req(1'b0, acc_size_e'(s[1:0]), u[0], word_addr(20, o),
                                         '0));
                end
            end
        end

        for (int i = 0; i <= 20; i++) begin
            fetch_access(word_addr(i, 0));
            fetch_access(word_addr(i, 4));
        end

        // misaligned store and load followed by the aligned word
        lsu_access(build_req(1'b1, SZ_D, 1'b0, word_addr(30, 0), rand_word()));
        for (int s = 1; s < 4; s++) begin
            nb = 1 << s;
            for (int o = 1; o < `XLEN_BYTES; o++) begin
                if (o % nb != 0) begin
                    lsu_access(build_req(1'b1, acc_size_e'(s[1:0]), 1'b0, word_addr(30, o),
                                         rand_word()));
                    lsu_access(build_req(1'b0, acc_size_e'(s[1:0]), 1'b0, word_addr(30, o),
                                         '0));
                    lsu_access(build_req(1'b0, SZ_D, 1'b0, word_addr(30, 0), '0));
                end
            end
        end
        for (int o = 1; o < `XLEN_BYTES; o++) begin
            if (o != 4) fetch_access(word_addr(30, o));
        end

        fork
            for (int i = 0; i < N_RAND; i++) lsu_access(lsu_rand[i]);
            for (int i = 0; i < N_RAND; i++) fetch_access(fetch_rand[i]);
        join

        // a few idle cycles catch any stray response
        repeat (4) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
mem_pkg.sv
data_ram.sv
mem_arbiter.sv
lsu_port.sv
fetch_port.sv
mem_subsys_top.sv
mem_assertions.sv
tb_mem_subsys.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_mem_subsys -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_mem_subsys

clean:
	rm -rf $(OBJ_DIR)
